//--- files.f
+incdir+.
portalPkg.sv
portalFifo.sv
burstSplitter.sv
readResponder.sv
writeCommitter.sv
portalBridge.sv
portalChecker.sv
portalBridgeTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module portalBridgeTb \
  -f files.f -Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi

//--- portalBridgeTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module portalBridgeTb;

  localparam int rows = 20;
  localparam int addrRecW = `PORTAL_ADDR_W + `PORTAL_LEN_W + `PORTAL_ID_W;

  typedef struct packed {
    logic wr;
    logic calm;                                 // Idle before and after, steady user core
    logic [`PORTAL_ADDR_W-1:0] addr;
    logic [`PORTAL_LEN_W-1:0] len;
    portalPkg::beatId id;
    logic [1:0] indN;                           // Indications offered at row start
    logic [0:3][`PORTAL_DATA_W-1:0] words;      // Write data or expected read data
    logic [0:1][`PORTAL_DATA_W-1:0] ind;
  } tableRow;

  tableRow tbl [rows];
  logic CLK;
  logic RST_N = 1'b0;
  logic arValid = 1'b0;
  logic [`PORTAL_ADDR_W-1:0] arAddr = '0;
  logic [`PORTAL_LEN_W-1:0] arLen = '0;
  portalPkg::beatId arId = '0;
  logic arReady;
  logic rValid;
  logic rReady = 1'b0;
  portalPkg::dataWord rData;
  portalPkg::beatId rId;
  logic rLast;
  logic awValid = 1'b0;
  logic [`PORTAL_ADDR_W-1:0] awAddr = '0;
  logic [`PORTAL_LEN_W-1:0] awLen = '0;
  portalPkg::beatId awId = '0;
  logic awReady;
  logic wValid = 1'b0;
  portalPkg::dataWord wData = '0;
  logic wReady;
  logic bValid;
  logic bReady = 1'b0;
  portalPkg::beatId bId;
  logic reqEnq;
  portalPkg::dataWord reqData;
  logic reqReady = 1'b0;
  logic indValid = 1'b0;
  portalPkg::dataWord indData = '0;
  logic indDeq;
  logic interrupt;

  logic [addrRecW-1:0] arQ[$];
  logic [addrRecW-1:0] awQ[$];
  portalPkg::dataWord wQ[$];
  portalPkg::dataWord indQ[$];    // User core indication queue
  logic calm = 1'b1;
  logic [31:0] lfsr = 32'h5cbe_7296;

  portalBridge dut0 (.*);
  portalChecker chk0 (.*);

  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    if (!RST_N) begin
      arValid <= 1'b0;
    end else if (!arValid || arReady) begin
      arValid <= arQ.size() > 0;
      if (arQ.size() > 0) {arAddr, arLen, arId} <= arQ.pop_front();
    end
  end

  always @(posedge CLK) begin
    if (!RST_N) begin
      awValid <= 1'b0;
    end else if (!awValid || awReady) begin
      awValid <= awQ.size() > 0;
      if (awQ.size() > 0) {awAddr, awLen, awId} <= awQ.pop_front();
    end
  end

  always @(posedge CLK) begin
    if (!RST_N) begin
      wValid <= 1'b0;
    end else if (!wValid || wReady) begin
      wValid <= wQ.size() > 0;
      if (wQ.size() > 0) wData <= wQ.pop_front();
    end
  end

  // Response stalls and user core model
  always @(posedge CLK) begin
    lfsr = galoisStep(lfsr);
    rReady <= lfsr[0];
    lfsr = galoisStep(lfsr);
    bReady <= lfsr[0];
    lfsr = galoisStep(lfsr);
    reqReady <= calm || lfsr[0];
    lfsr = galoisStep(lfsr);
    if (indDeq) void'(indQ.pop_front());
    indValid <= indQ.size() > 0 && (calm || lfsr[0]);
    indData <= (indQ.size() > 0) ? indQ[0] : '0;
  end

  task automatic fillTable();
    tbl[0] = '{1'b0, 1'b1, 12'h008, 4'd3, 6'd1, 2'd0, {32'd1, 32'd0, 32'd5, 32'd1}, 64'd0};
    tbl[1] = '{1'b0, 1'b1, 12'h01C, 4'd0, 6'd2, 2'd0, {32'h005A05A0, 96'd0}, 64'd0};
    tbl[2] = '{1'b1, 1'b0, 12'h020, 4'd3, 6'd3, 2'd0,
               {32'h1001, 32'h1002, 32'h1003, 32'h1004}, 64'd0};
    tbl[3] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd4, 2'd2, {32'hA001, 96'd0}, {32'hA001, 32'hA002}};
    tbl[4] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd5, 2'd0, {32'hA002, 96'd0}, 64'd0};
    tbl[5] = '{1'b0, 1'b1, 12'h024, 4'd0, 6'd6, 2'd0, {32'd1, 96'd0}, 64'd0};
    tbl[6] = '{1'b1, 1'b1, 12'h004, 4'd0, 6'd7, 2'd0, {32'd1, 96'd0}, 64'd0};
    tbl[7] = '{1'b0, 1'b1, 12'h000, 4'd0, 6'd8, 2'd1, {32'd1, 96'd0}, {32'hC0FFEE01, 32'd0}};
    tbl[8] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd9, 2'd0, {32'hC0FFEE01, 96'd0}, 64'd0};
    tbl[9] = '{1'b0, 1'b1, 12'h000, 4'd1, 6'd10, 2'd0, {32'd0, 32'd1, 64'd0}, 64'd0};
    tbl[10] = '{1'b1, 1'b1, 12'h004, 4'd0, 6'd11, 2'd0, 128'd0, 64'd0};
    tbl[11] = '{1'b0, 1'b1, 12'h014, 4'd3, 6'd12, 2'd1,
                {32'd1, 32'h005A05A0, 32'h005A05A0, 32'd1}, {32'hD00D0001, 32'd0}};
    tbl[12] = '{1'b1, 1'b0, 12'h020, 4'd1, 6'd13, 2'd0, {32'h2001, 32'h2002, 64'd0}, 64'd0};
    tbl[13] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd14, 2'd2,
                {32'hD00D0001, 96'd0}, {32'hE001, 32'hE002}};
    tbl[14] = '{1'b1, 1'b0, 12'h028, 4'd3, 6'd15, 2'd0,
                {32'h3001, 32'h3002, 32'h3003, 32'h3004}, 64'd0};
    tbl[15] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd16, 2'd0, {32'hE001, 96'd0}, 64'd0};
    tbl[16] = '{1'b0, 1'b0, 12'h010, 4'd1, 6'd17, 2'd0, {32'd5, 32'd1, 64'd0}, 64'd0};
    tbl[17] = '{1'b0, 1'b0, 12'h020, 4'd0, 6'd18, 2'd0, {32'hE002, 96'd0}, 64'd0};
    tbl[18] = '{1'b1, 1'b0, 12'h030, 4'd0, 6'd19, 2'd0, {32'h4001, 96'd0}, 64'd0};
    tbl[19] = '{1'b0, 1'b0, 12'h02C, 4'd1, 6'd20, 2'd0, 128'd0, 64'd0};   // Unused data offsets
  endtask

  // Bus drivers empty and every expected response seen
  task automatic waitIdle();
    while (arQ.size() > 0 || awQ.size() > 0 || wQ.size() > 0 || arValid || awValid ||
           wValid || chk0.pending() > 0) begin
      @(posedge CLK);
    end
  endtask

  initial begin
    portalPkg::wordOffset ofs;
    logic ctrl;
    logic enableHit;
    logic enableState;
    enableState = 1'b0;
    fillTable();
    repeat (8) @(posedge CLK);
    RST_N <= 1'b1;
    @(posedge CLK);
    for (int r = 0; r < rows; r++) begin
      if (tbl[r].calm) waitIdle();
      calm = tbl[r].calm;
      enableHit = 1'b0;
      for (int i = 0; i < int'(tbl[r].indN); i++) indQ.push_back(tbl[r].ind[i]);
      @(posedge CLK);
      ctrl = tbl[r].addr[`PORTAL_ADDR_W-1:`PORTAL_OFS_W] == '0;
      for (int i = 0; i <= int'(tbl[r].len); i++) begin
        ofs = tbl[r].addr[`PORTAL_OFS_W-1:0] + portalPkg::wordOffset'(4 * i);   // Wraps
        if (!tbl[r].wr) begin
          chk0.expectRead(tbl[r].words[i], tbl[r].id, i == int'(tbl[r].len));
        end else begin
          wQ.push_back(tbl[r].words[i]);
          if (!ctrl) begin
            chk0.expectRequest(tbl[r].words[i]);
          end else if (ofs == `CTRL_INT_ENABLE) begin
            enableHit = 1'b1;
            enableState = tbl[r].words[i][0];
          end
        end
      end
      if (enableHit) chk0.setInterruptState(1'b0, enableState);
      if (tbl[r].wr) begin
        chk0.expectWrite(tbl[r].id);
        awQ.push_back({tbl[r].addr, tbl[r].len, tbl[r].id});
      end else begin
        arQ.push_back({tbl[r].addr, tbl[r].len, tbl[r].id});
      end
      if (tbl[r].calm || enableHit) waitIdle();
      if (enableHit) chk0.setInterruptState(1'b1, enableState);
    end
    waitIdle();
    repeat (4) @(posedge CLK);
    if (indQ.size() > 0) chk0.reportProblem("indications were left unread by the bridge");
    chk0.finalReport();
    if (chk0.totalErrors() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (rows * 200) @(posedge CLK);
    $display("Timeout: the bridge stopped responding before the table was done");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- portalChecker.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module portalChecker (
  input wire                     CLK,
  input wire                     RST_N,
  input wire                     arReady,
  input wire                     awReady,
  input wire                     rValid,
  input wire                     rReady,
  input wire portalPkg::dataWord rData,
  input wire portalPkg::beatId   rId,
  input wire                     rLast,
  input wire                     bValid,
  input wire                     bReady,
  input wire portalPkg::beatId   bId,
  input wire                     reqEnq,
  input wire portalPkg::dataWord reqData,
  input wire                     reqReady,
  input wire                     indValid,
  input wire                     indDeq,
  input wire                     interrupt
);

  portalPkg::readBeat rExp[$];
  portalPkg::beatId bExp[$];
  portalPkg::dataWord reqExp[$];
  int mismatches = 0;
  int otherErrors = 0;
  logic intKnown = 1'b1;    // Enable state settled
  logic expEnable = 1'b0;
  logic inReset = 1'b1;

  task automatic expectRead(input portalPkg::dataWord data, input portalPkg::beatId id,
                            input logic last);
    portalPkg::readBeat entry;
    entry.data = data;
    entry.id = id;
    entry.last = last;
    rExp.push_back(entry);
  endtask

  task automatic expectWrite(input portalPkg::beatId id);
    bExp.push_back(id);
  endtask

  task automatic expectRequest(input portalPkg::dataWord data);
    reqExp.push_back(data);
  endtask

  task automatic setInterruptState(input logic known, input logic enable);
    intKnown = known;
    expEnable = enable;
  endtask

  task automatic reportProblem(input string msg);
    otherErrors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic compare(input string name, input logic [31:0] expV, input logic [31:0] got);
    if (expV !== got) begin
      mismatches++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expV, got);
    end
  endtask

  function automatic int pending();
    return rExp.size() + bExp.size() + reqExp.size();
  endfunction

  function automatic int totalErrors();
    return mismatches + otherErrors;
  endfunction

  always @(posedge CLK) begin
    portalPkg::readBeat head;
    if (!RST_N) begin
      inReset <= 1'b1;
    end else begin
      if (inReset && (!arReady || !awReady || rValid || bValid || reqEnq || indDeq ||
                      interrupt)) begin
        reportProblem("bridge outputs were not in their reset state after reset");
      end
      inReset <= 1'b0;
      if (rValid && rReady) begin
        if (rExp.size() == 0) begin
          reportProblem("R beat arrived with no read outstanding");
        end else begin
          head = rExp.pop_front();
          compare("rData", head.data, rData);
          compare("rId", 32'(head.id), 32'(rId));
          compare("rLast", 32'(head.last), 32'(rLast));
        end
      end
      if (bValid && bReady) begin
        if (bExp.size() == 0) begin
          reportProblem("B response arrived with no write outstanding");
        end else begin
          compare("bId", 32'(bExp.pop_front()), 32'(bId));
        end
      end
      if (reqEnq) begin
        if (!reqReady) reportProblem("reqEnq was issued while reqReady was low");
        if (reqExp.size() == 0) begin
          reportProblem("request sent to the user core that no write asked for");
        end else begin
          compare("reqData", reqExp.pop_front(), reqData);
        end
      end
      if (indDeq && !indValid) reportProblem("indDeq was pulsed with no indication present");
      if (intKnown) compare("interrupt", 32'(expEnable && indValid), 32'(interrupt));
    end
  end

  task automatic finalReport();
    if (rExp.size() > 0) reportProblem($sformatf("%0d read beats never returned", rExp.size()));
    if (bExp.size() > 0) reportProblem($sformatf("%0d write responses missing", bExp.size()));
    if (reqExp.size() > 0) reportProblem($sformatf("%0d requests never sent", reqExp.size()));
    $display("Error count: %0d value mismatches, %0d other failures", mismatches, otherErrors);
  endtask

endmodule

`default_nettype wire

//--- portalBridge.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module portalBridge (
  input  wire                      CLK,
  input  wire                      RST_N,
  // Read address and data
  input  wire                      arValid,
  output wire                      arReady,
  input  wire [`PORTAL_ADDR_W-1:0] arAddr,
  input  wire [`PORTAL_LEN_W-1:0]  arLen,
  input  wire portalPkg::beatId    arId,
  output wire                      rValid,
  input  wire                      rReady,
  output wire portalPkg::dataWord  rData,
  output wire portalPkg::beatId    rId,
  output wire                      rLast,
  // Write address, data and response
  input  wire                      awValid,
  output wire                      awReady,
  input  wire [`PORTAL_ADDR_W-1:0] awAddr,
  input  wire [`PORTAL_LEN_W-1:0]  awLen,
  input  wire portalPkg::beatId    awId,
  input  wire                      wValid,
  output wire                      wReady,
  input  wire portalPkg::dataWord  wData,
  output wire                      bValid,
  input  wire                      bReady,
  output wire portalPkg::beatId    bId,
  // User core
  output wire                      reqEnq,
  output wire portalPkg::dataWord  reqData,
  input  wire                      reqReady,
  input  wire                      indValid,
  input  wire portalPkg::dataWord  indData,
  output wire                      indDeq,
  output wire                      interrupt
);

  wire rdBeatValid, rdBeatTake;
  wire wrBeatValid, wrBeatTake;
  wire portalPkg::beatEntry rdBeat;
  wire portalPkg::beatEntry wrBeat;
  wire intEnable;

  burstSplitter readSplit (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(arValid), .addrReady(arReady), .addr(arAddr), .len(arLen), .id(arId),
    .beatValid(rdBeatValid), .beat(rdBeat), .beatTake(rdBeatTake)
  );

  burstSplitter writeSplit (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(awValid), .addrReady(awReady), .addr(awAddr), .len(awLen), .id(awId),
    .beatValid(wrBeatValid), .beat(wrBeat), .beatTake(wrBeatTake)
  );

  readResponder reader (
    .CLK(CLK), .RST_N(RST_N),
    .beatValid(rdBeatValid), .beat(rdBeat), .beatTake(rdBeatTake),
    .intEnable(intEnable), .indValid(indValid), .indData(indData), .indDeq(indDeq),
    .reqReady(reqReady),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast)
  );

  writeCommitter writer (
    .CLK(CLK), .RST_N(RST_N),
    .beatValid(wrBeatValid), .beat(wrBeat), .beatTake(wrBeatTake),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .reqEnq(reqEnq), .reqData(reqData), .reqReady(reqReady),
    .indValid(indValid), .intEnable(intEnable), .interrupt(interrupt),
    .bValid(bValid), .bReady(bReady), .bId(bId)
  );

endmodule

`default_nettype wire

//--- writeCommitter.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module writeCommitter (
  input  wire                      CLK,
  input  wire                      RST_N,
  input  wire                      beatValid,
  input  wire portalPkg::beatEntry beat,
  output logic                     beatTake,
  input  wire                      wValid,
  output logic                     wReady,
  input  wire portalPkg::dataWord  wData,
  output logic                     reqEnq,
  output portalPkg::dataWord       reqData,
  input  wire                      reqReady,
  input  wire                      indValid,
  output logic                     intEnable,
  output logic                     interrupt,
  output logic                     bValid,
  input  wire                      bReady,
  output portalPkg::beatId         bId
);

  portalPkg::dataWord dataHead;
  logic dataFull, dataEmpty;
  logic respFull, respEmpty;
  logic commit;
  logic enableWrite;

  assign wReady = !dataFull;

  portalFifo #(.T(portalPkg::dataWord), .depth(`PORTAL_BEAT_DEPTH)) dataQ (
    .CLK(CLK), .RST_N(RST_N),
    .push(wValid && wReady), .pushData(wData), .full(dataFull),
    .pop(commit), .popData(dataHead), .empty(dataEmpty)
  );

  // Beat and word paired; data writes need request room, last beat needs a B slot
  assign commit = beatValid && !dataEmpty && (beat.ctrl || reqReady) &&
                  (!beat.last || !respFull);
  assign beatTake = commit;
  assign reqEnq = commit && !beat.ctrl;
  assign reqData = dataHead;

  // Only the enable bit is writable in the control region
  assign enableWrite = commit && beat.ctrl && beat.ofs == `CTRL_INT_ENABLE;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intEnable <= 1'b0;
    end else if (enableWrite) begin
      intEnable <= dataHead[0];
    end
  end

  assign interrupt = intEnable && indValid;

  portalFifo #(.T(portalPkg::beatId), .depth(`PORTAL_BEAT_DEPTH)) respQ (
    .CLK(CLK), .RST_N(RST_N),
    .push(commit && beat.last), .pushData(beat.id), .full(respFull),
    .pop(bValid && bReady), .popData(bId), .empty(respEmpty)
  );

  assign bValid = !respEmpty;   // One cycle after the last beat

endmodule

`default_nettype wire

//--- readResponder.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module readResponder (
  input  wire                      CLK,
  input  wire                      RST_N,
  input  wire                      beatValid,
  input  wire portalPkg::beatEntry beat,
  output logic                     beatTake,
  input  wire                      intEnable,
  input  wire                      indValid,
  input  wire portalPkg::dataWord  indData,
  output logic                     indDeq,
  input  wire                      reqReady,
  output logic                     rValid,
  input  wire                      rReady,
  output portalPkg::dataWord       rData,
  output portalPkg::beatId         rId,
  output logic                     rLast
);

  portalPkg::dataWord ctrlWord;
  portalPkg::dataWord portalWord;
  portalPkg::readBeat respIn;
  portalPkg::readBeat respHead;
  logic indRead;
  logic commit;
  logic respFull, respEmpty;

  assign indRead = !beat.ctrl && beat.ofs == `DATA_IND_OFS;

  // An indication read stalls until the core presents a word
  assign commit = beatValid && !respFull && (!indRead || indValid);
  assign beatTake = commit;
  assign indDeq = commit && indRead;

  // Control register file
  always_comb begin
    case (beat.ofs)
      `CTRL_INT_STATUS, `CTRL_QUEUE_STATUS: ctrlWord = portalPkg::dataWord'(indValid);
      `CTRL_INT_ENABLE:  ctrlWord = portalPkg::dataWord'(intEnable);
      `CTRL_NUM_TILES:   ctrlWord = `VAL_NUM_TILES;
      `CTRL_PORTAL_ID:   ctrlWord = `VAL_PORTAL_ID;
      `CTRL_NUM_PORTALS: ctrlWord = `VAL_NUM_PORTALS;
      default:           ctrlWord = `VAL_UNMAPPED;
    endcase
  end

  always_comb begin
    case (beat.ofs)
      `DATA_IND_OFS:     portalWord = indData;
      `DATA_NOTFULL_OFS: portalWord = portalPkg::dataWord'(reqReady);   // Request room
      default:           portalWord = '0;
    endcase
  end

  always_comb begin
    respIn.data = beat.ctrl ? ctrlWord : portalWord;
    respIn.id = beat.id;
    respIn.last = beat.last;
  end

  portalFifo #(.T(portalPkg::readBeat), .depth(`PORTAL_BEAT_DEPTH)) respQ (
    .CLK(CLK), .RST_N(RST_N),
    .push(commit), .pushData(respIn), .full(respFull),
    .pop(rValid && rReady), .popData(respHead), .empty(respEmpty)
  );

  assign rValid = !respEmpty;
  assign rData = respHead.data;
  assign rId = respHead.id;
  assign rLast = respHead.last;

endmodule

`default_nettype wire

//--- burstSplitter.sv
`timescale 1ns/100ps
`default_nettype none
`include "portal_params.svh"

module burstSplitter (
  input  wire                      CLK,
  input  wire                      RST_N,
  input  wire                      addrValid,
  output logic                     addrReady,
  input  wire [`PORTAL_ADDR_W-1:0] addr,
  input  wire [`PORTAL_LEN_W-1:0]  len,
  input  wire portalPkg::beatId    id,
  output logic                     beatValid,
  output portalPkg::beatEntry      beat,
  input  wire                      beatTake
);

  portalPkg::burstReq inBurst;
  portalPkg::burstReq headBurst;
  portalPkg::beatEntry nextBeat;
  portalPkg::wordOffset curOfs;
  portalPkg::wordOffset ofsNow;
  logic [`PORTAL_LEN_W-1:0] remaining;
  logic [`PORTAL_LEN_W-1:0] remNow;
  logic firstBeat;
  logic lastNow;
  logic beatPush;
  logic burstFull, burstEmpty, beatFull, beatEmpty;

  always_comb begin
    inBurst.ofs = addr[`PORTAL_OFS_W-1:0];
    inBurst.len = len;
    inBurst.id = id;
    // Upper address bits all zero select the control region
    inBurst.ctrl = addr[`PORTAL_ADDR_W-1:`PORTAL_OFS_W] == '0;
  end

  assign addrReady = !burstFull;

  portalFifo #(.T(portalPkg::burstReq), .depth(`PORTAL_ADDR_DEPTH)) burstQ (
    .CLK(CLK), .RST_N(RST_N),
    .push(addrValid && addrReady), .pushData(inBurst), .full(burstFull),
    .pop(beatPush && lastNow), .popData(headBurst), .empty(burstEmpty)
  );

  // Walk the head burst
  assign ofsNow = firstBeat ? headBurst.ofs : curOfs;
  assign remNow = firstBeat ? headBurst.len : remaining;
  assign lastNow = remNow == '0;
  assign beatPush = !burstEmpty && !beatFull;

  always_comb begin
    nextBeat.ofs = ofsNow;
    nextBeat.id = headBurst.id;
    nextBeat.ctrl = headBurst.ctrl;
    nextBeat.last = lastNow;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      firstBeat <= 1'b1;
      curOfs <= '0;
      remaining <= '0;
    end else if (beatPush) begin
      curOfs <= ofsNow + portalPkg::wordOffset'(4);   // Wraps inside the region
      remaining <= remNow - 1'b1;
      firstBeat <= lastNow;
    end
  end

  portalFifo #(.T(portalPkg::beatEntry), .depth(`PORTAL_BEAT_DEPTH)) beatQ (
    .CLK(CLK), .RST_N(RST_N),
    .push(beatPush), .pushData(nextBeat), .full(beatFull),
    .pop(beatTake), .popData(beat), .empty(beatEmpty)
  );

  assign beatValid = !beatEmpty;

endmodule

`default_nettype wire

//--- portalFifo.sv
`timescale 1ns/100ps
`default_nettype none

module portalFifo #(
  parameter type T = logic,
  parameter int depth = 2
) (
  input  wire   CLK,
  input  wire   RST_N,
  input  wire   push,
  input  wire T pushData,
  output logic  full,
  input  wire   pop,
  output T      popData,
  output logic  empty
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  T mem [depth];
  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [cntW-1:0] count;
  logic doPush;
  logic doPop;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
    return (p == ptrW'(depth - 1)) ? '0 : p + 1'b1;   // Wrap at depth
  endfunction

  assign full = count == cntW'(depth);
  assign empty = count == '0;
  assign doPush = push && !full;
  assign doPop = pop && !empty;
  assign popData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- portalPkg.sv
`default_nettype none
`include "portal_params.svh"

package portalPkg;

  typedef logic [`PORTAL_DATA_W-1:0] dataWord;
  typedef logic [`PORTAL_ID_W-1:0] beatId;
  typedef logic [`PORTAL_OFS_W-1:0] wordOffset;

  // One queued address burst
  typedef struct packed {
    wordOffset ofs;
    logic [`PORTAL_LEN_W-1:0] len;
    beatId id;
    logic ctrl;    // Control region hit
  } burstReq;

  typedef struct packed {
    wordOffset ofs;
    beatId id;
    logic ctrl;
    logic last;    // Final word of its burst
  } beatEntry;

  typedef struct packed {
    dataWord data;
    beatId id;
    logic last;
  } readBeat;

endpackage

`default_nettype wire

//--- portal_params.svh
`ifndef PORTAL_PARAMS_SVH
`define PORTAL_PARAMS_SVH

// Bus geometry
`define PORTAL_DATA_W 32
`define PORTAL_ID_W 6
`define PORTAL_LEN_W 4     // Beats minus one
`define PORTAL_ADDR_W 12
`define PORTAL_OFS_W 5

// Queue depths
`define PORTAL_ADDR_DEPTH 2
`define PORTAL_BEAT_DEPTH 2

// Control region offsets
`define CTRL_INT_STATUS 5'h00
`define CTRL_INT_ENABLE 5'h04
`define CTRL_NUM_TILES 5'h08
`define CTRL_QUEUE_STATUS 5'h0C
`define CTRL_PORTAL_ID 5'h10
`define CTRL_NUM_PORTALS 5'h14

// Data region offsets
`define DATA_IND_OFS 5'h00
`define DATA_NOTFULL_OFS 5'h04

// Constant register contents
`define VAL_NUM_TILES 32'd1
`define VAL_PORTAL_ID 32'd5
`define VAL_NUM_PORTALS 32'd1
`define VAL_UNMAPPED 32'h005A05A0

`endif
